//--- source/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// register and memory word width
`define DATA_WIDTH 16

// full instruction including the long-immediate tag in [17:16]
`define INST_WIDTH 18

// register file size, 4-bit indices
`define REG_COUNT 16

// data memory words, 8-bit addresses
`define MEM_DEPTH 256

`endif

//--- source/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// alu operations selected by the decoder
	typedef enum logic [4:0] {
		opAdd,
		opAddu,
		opAddc,
		opAddcu,
		opSub,
		opCmp,
		opCmpu,
		opAnd,
		opOr,
		opXor,
		opNot,
		opMov,
		opLsh,
		opRsh,
		opAlsh,
		opArsh,
		// operand B straight through, immediates and LUI
		opPass
	} aluOp_e;

	// load sequencer, second cycle of LOAD waits on the memory
	typedef enum logic {
		seqIdle,
		seqLoadWait
	} seqState_e;

endpackage

`default_nettype wire

//--- source/decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module decoder (
	input  logic [`INST_WIDTH-1:0]        inst,
	input  logic                          instValid,
	output cpuPkg::aluOp_e                aluOp,
	output logic [`DATA_WIDTH-1:0]        imm,
	output logic                          selectImm,
	output logic                          regWrite,
	output logic                          memRead,
	output logic                          memWrite,
	output logic [$clog2(`REG_COUNT)-1:0] readRegA,
	output logic [$clog2(`REG_COUNT)-1:0] readRegB,
	output logic [$clog2(`REG_COUNT)-1:0] writeReg
);
	import cpuPkg::*;

	//////////////////////////////////////////////////
	// primary opcodes, inst[15:12]
	localparam logic [3:0] primRtype  = 4'b0000;
	localparam logic [3:0] primMem    = 4'b0100;
	localparam logic [3:0] primAddi   = 4'b0101;
	localparam logic [3:0] primAddui  = 4'b0110;
	localparam logic [3:0] primAddci  = 4'b0111;
	localparam logic [3:0] primShift  = 4'b1000;
	localparam logic [3:0] primSubi   = 4'b1001;
	localparam logic [3:0] primAddcui = 4'b1010;
	localparam logic [3:0] primCmpi   = 4'b1011;
	localparam logic [3:0] primMovi   = 4'b1101;
	localparam logic [3:0] primCmpui  = 4'b1110;
	localparam logic [3:0] primLui    = 4'b1111;

	// secondary opcodes, inst[7:4]
	localparam logic [3:0] secAnd   = 4'b0001;
	localparam logic [3:0] secOr    = 4'b0010;
	localparam logic [3:0] secXor   = 4'b0011;
	localparam logic [3:0] secAddcu = 4'b0100;
	localparam logic [3:0] secAdd   = 4'b0101;
	localparam logic [3:0] secAddu  = 4'b0110;
	localparam logic [3:0] secAddc  = 4'b0111;
	localparam logic [3:0] secSub   = 4'b1001;
	localparam logic [3:0] secCmp   = 4'b1011;
	localparam logic [3:0] secMov   = 4'b1101;
	localparam logic [3:0] secNot   = 4'b1111;
	localparam logic [3:0] shLshi   = 4'b0000;
	localparam logic [3:0] shRshi   = 4'b0001;
	localparam logic [3:0] shLsh    = 4'b0100;
	localparam logic [3:0] shAlsh   = 4'b0101;
	localparam logic [3:0] shRsh    = 4'b1100;
	localparam logic [3:0] shArsh   = 4'b1101;
	localparam logic [3:0] memLoad  = 4'b0000;
	localparam logic [3:0] memStor  = 4'b0100;
	//////////////////////////////////////////////////

	logic [`DATA_WIDTH-1:0] immSext;
	logic [`DATA_WIDTH-1:0] immZext;
	logic [`DATA_WIDTH-1:0] immShift;
	logic                   wrDec;
	logic                   rdDec;
	logic                   wmDec;

	assign immSext  = {{(`DATA_WIDTH-8){inst[7]}}, inst[7:0]};
	assign immZext  = {{(`DATA_WIDTH-8){1'b0}}, inst[7:0]};
	assign immShift = {{(`DATA_WIDTH-4){1'b0}}, inst[3:0]};

	always_comb begin
		aluOp     = opPass;
		imm       = '0;
		selectImm = 1'b0;
		readRegA  = inst[11:8];
		readRegB  = inst[3:0];
		writeReg  = inst[11:8];
		wrDec     = 1'b0;
		rdDec     = 1'b0;
		wmDec     = 1'b0;
		if (inst[17:16] == 2'b11) begin
			// long immediate, whole low half goes to the register
			imm       = inst[`DATA_WIDTH-1:0];
			selectImm = 1'b1;
			wrDec     = 1'b1;
		end else if (inst[17:16] == 2'b00) begin
			case (inst[15:12])
				primRtype: begin
					wrDec = 1'b1;
					case (inst[7:4])
						secAdd:   aluOp = opAdd;
						secAddu:  aluOp = opAddu;
						secAddc:  aluOp = opAddc;
						secAddcu: aluOp = opAddcu;
						secSub:   aluOp = opSub;
						secAnd:   aluOp = opAnd;
						secOr:    aluOp = opOr;
						secXor:   aluOp = opXor;
						secNot:   aluOp = opNot;
						secCmp: begin
							aluOp = opCmp;
							wrDec = 1'b0;
						end
						secMov: begin
							// source register comes in on port A
							aluOp    = opMov;
							readRegA = inst[3:0];
						end
						default: wrDec = 1'b0;
					endcase
				end
				primShift: begin
					wrDec = 1'b1;
					case (inst[7:4])
						shLsh:  aluOp = opLsh;
						shAlsh: aluOp = opAlsh;
						shRsh:  aluOp = opRsh;
						shArsh: aluOp = opArsh;
						shLshi: begin
							aluOp     = opLsh;
							imm       = immShift;
							selectImm = 1'b1;
						end
						shRshi: begin
							aluOp     = opRsh;
							imm       = immShift;
							selectImm = 1'b1;
						end
						default: wrDec = 1'b0;
					endcase
				end
				primMem: begin
					case (inst[7:4])
						memLoad: begin
							// address register sits in the low field for LOAD
							readRegA = inst[3:0];
							rdDec    = 1'b1;
						end
						memStor: wmDec = 1'b1;
						default: wmDec = 1'b0;
					endcase
				end
				primAddi: begin
					aluOp = opAdd;
					imm   = immSext;
					wrDec = 1'b1;
				end
				primAddui: begin
					aluOp = opAddu;
					imm   = immZext;
					wrDec = 1'b1;
				end
				primAddci: begin
					aluOp = opAddc;
					imm   = immSext;
					wrDec = 1'b1;
				end
				primAddcui: begin
					aluOp = opAddcu;
					imm   = immZext;
					wrDec = 1'b1;
				end
				primSubi: begin
					aluOp = opSub;
					imm   = immSext;
					wrDec = 1'b1;
				end
				primCmpi: begin
					aluOp = opCmp;
					imm   = immSext;
				end
				primCmpui: begin
					aluOp = opCmpu;
					imm   = immZext;
				end
				primMovi: begin
					imm   = immZext;
					wrDec = 1'b1;
				end
				primLui: begin
					imm   = {inst[7:0], {(`DATA_WIDTH-8){1'b0}}};
					wrDec = 1'b1;
				end
				default: wrDec = 1'b0;
			endcase
			// every primary opcode except R-type, shift and memory carries imm8
			selectImm = selectImm | ((inst[15:12] != primRtype) &&
				(inst[15:12] != primShift) && (inst[15:12] != primMem));
		end
	end

	assign regWrite = instValid & wrDec;
	assign memRead  = instValid & rdDec;
	assign memWrite = instValid & wmDec;

endmodule

`default_nettype wire

//--- source/registerFile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module registerFile (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [$clog2(`REG_COUNT)-1:0] readRegA,
	input  logic [$clog2(`REG_COUNT)-1:0] readRegB,
	input  logic [$clog2(`REG_COUNT)-1:0] writeReg,
	input  logic                          writeEn,
	input  logic [`DATA_WIDTH-1:0]        writeData,
	output logic [`DATA_WIDTH-1:0]        dataA,
	output logic [`DATA_WIDTH-1:0]        dataB
);

	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	// reads see the old value during a write cycle
	assign dataA = regs[readRegA];
	assign dataB = regs[readRegB];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeReg] <= writeData;
		end
	end

endmodule

`default_nettype wire

//--- source/executeUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module executeUnit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   accept,
	input  cpuPkg::aluOp_e         aluOp,
	input  logic [`DATA_WIDTH-1:0] operandA,
	input  logic [`DATA_WIDTH-1:0] regB,
	input  logic [`DATA_WIDTH-1:0] imm,
	input  logic                   selectImm,
	output logic [`DATA_WIDTH-1:0] result,
	output logic                   flagC,
	output logic                   flagZ,
	output logic                   flagN,
	output logic                   flagL
);
	import cpuPkg::*;

	logic [`DATA_WIDTH-1:0] operandB;
	logic [`DATA_WIDTH:0]   sum;
	logic [`DATA_WIDTH:0]   diff;
	logic                   carryIn;
	logic [3:0]             shamt;

	assign operandB = selectImm ? imm : regB;
	assign carryIn  = (aluOp == opAddc) || (aluOp == opAddcu) ? flagC : 1'b0;

	// msb of sum is carry out, msb of diff is borrow
	assign sum   = {1'b0, operandA} + {1'b0, operandB} + carryIn;
	assign diff  = {1'b0, operandA} - {1'b0, operandB};
	assign shamt = operandB[3:0];

	always_comb begin
		case (aluOp)
			opAdd, opAddu, opAddc, opAddcu: result = sum[`DATA_WIDTH-1:0];
			opSub, opCmp, opCmpu:           result = diff[`DATA_WIDTH-1:0];
			opAnd:                          result = operandA & operandB;
			opOr:                           result = operandA | operandB;
			opXor:                          result = operandA ^ operandB;
			opNot:                          result = ~operandB;
			opMov:                          result = operandA;
			opLsh, opAlsh:                  result = operandA << shamt;
			opRsh:                          result = operandA >> shamt;
			opArsh:                         result = $unsigned($signed(operandA) >>> shamt);
			default:                        result = operandB;
		endcase
	end

	//////////////////////////////////////////////////
	// flags, only the ones the operation defines
	always_ff @(posedge clk) begin
		if (rst) begin
			flagC <= 1'b0;
			flagZ <= 1'b0;
			flagN <= 1'b0;
			flagL <= 1'b0;
		end else if (accept) begin
			case (aluOp)
				opAdd, opAddu, opAddc, opAddcu: flagC <= sum[`DATA_WIDTH];
				opSub: flagC <= diff[`DATA_WIDTH];
				opCmp, opCmpu: begin
					flagZ <= (operandA == operandB);
					flagN <= ($signed(operandA) < $signed(operandB));
					flagL <= diff[`DATA_WIDTH];
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module dataMemory (
	input  logic                          clk,
	input  logic                          writeEn,
	input  logic                          readEn,
	input  logic [$clog2(`MEM_DEPTH)-1:0] addr,
	input  logic [`DATA_WIDTH-1:0]        writeData,
	output logic [`DATA_WIDTH-1:0]        readData
);

	logic [`DATA_WIDTH-1:0] mem [`MEM_DEPTH];

	// single port, readData holds between reads
	always_ff @(posedge clk) begin
		if (writeEn) begin
			mem[addr] <= writeData;
		end
		if (readEn) begin
			readData <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- source/loadSequencer.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module loadSequencer (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          instValid,
	input  logic                          regWrite,
	input  logic                          memRead,
	input  logic [$clog2(`REG_COUNT)-1:0] writeReg,
	input  logic [`DATA_WIDTH-1:0]        result,
	input  logic [`DATA_WIDTH-1:0]        memData,
	output logic                          accept,
	output logic                          memReadEn,
	output logic                          rfWriteEn,
	output logic [$clog2(`REG_COUNT)-1:0] rfWriteReg,
	output logic [`DATA_WIDTH-1:0]        rfWriteData,
	output logic                          busy,
	output logic                          wbValid,
	output logic [$clog2(`REG_COUNT)-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]        wbData
);
	import cpuPkg::*;

	seqState_e                   state;
	logic [$clog2(`REG_COUNT)-1:0] loadDest;

	assign busy      = (state == seqLoadWait);
	assign accept    = instValid & ~busy;
	assign memReadEn = accept & memRead;

	// second LOAD cycle takes the write port from the alu path
	assign rfWriteEn   = busy | (accept & regWrite);
	assign rfWriteReg  = busy ? loadDest : writeReg;
	assign rfWriteData = busy ? memData : result;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= seqIdle;
		end else begin
			case (state)
				seqIdle:     state <= memReadEn ? seqLoadWait : seqIdle;
				seqLoadWait: state <= seqIdle;
				default:     state <= seqIdle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (memReadEn) begin
			loadDest <= writeReg;
		end
	end

	//////////////////////////////////////////////////
	// writeback report, one cycle after the write
	always_ff @(posedge clk) begin
		if (rst) begin
			wbValid <= 1'b0;
		end else begin
			wbValid <= rfWriteEn;
		end
	end

	always_ff @(posedge clk) begin
		if (rfWriteEn) begin
			wbReg  <= rfWriteReg;
			wbData <= rfWriteData;
		end
	end

endmodule

`default_nettype wire

//--- source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuCore (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [`INST_WIDTH-1:0]        inst,
	input  logic                          instValid,
	output logic                          busy,
	output logic                          wbValid,
	output logic [$clog2(`REG_COUNT)-1:0] wbReg,
	output logic [`DATA_WIDTH-1:0]        wbData,
	output logic                          flagC,
	output logic                          flagZ,
	output logic                          flagN,
	output logic                          flagL
);
	import cpuPkg::*;

	aluOp_e                        aluOp;
	logic [`DATA_WIDTH-1:0]        imm;
	logic                          selectImm;
	logic                          regWrite;
	logic                          memRead;
	logic                          memWrite;
	logic [$clog2(`REG_COUNT)-1:0] readRegA;
	logic [$clog2(`REG_COUNT)-1:0] readRegB;
	logic [$clog2(`REG_COUNT)-1:0] writeReg;
	logic [`DATA_WIDTH-1:0]        dataA;
	logic [`DATA_WIDTH-1:0]        dataB;
	logic [`DATA_WIDTH-1:0]        result;
	logic [`DATA_WIDTH-1:0]        memData;
	logic                          accept;
	logic                          memReadEn;
	logic                          rfWriteEn;
	logic [$clog2(`REG_COUNT)-1:0] rfWriteReg;
	logic [`DATA_WIDTH-1:0]        rfWriteData;

	decoder decoder0 (
		.inst(inst),
		.instValid(instValid),
		.aluOp(aluOp),
		.imm(imm),
		.selectImm(selectImm),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.writeReg(writeReg)
	);

	registerFile registerFile0 (
		.clk(clk),
		.rst(rst),
		.readRegA(readRegA),
		.readRegB(readRegB),
		.writeReg(rfWriteReg),
		.writeEn(rfWriteEn),
		.writeData(rfWriteData),
		.dataA(dataA),
		.dataB(dataB)
	);

	executeUnit executeUnit0 (
		.clk(clk),
		.rst(rst),
		.accept(accept),
		.aluOp(aluOp),
		.operandA(dataA),
		.regB(dataB),
		.imm(imm),
		.selectImm(selectImm),
		.result(result),
		.flagC(flagC),
		.flagZ(flagZ),
		.flagN(flagN),
		.flagL(flagL)
	);

	// register A holds the address for both LOAD and STOR
	dataMemory dataMemory0 (
		.clk(clk),
		.writeEn(memWrite & accept),
		.readEn(memReadEn),
		.addr(dataA[$clog2(`MEM_DEPTH)-1:0]),
		.writeData(dataB),
		.readData(memData)
	);

	loadSequencer loadSequencer0 (
		.clk(clk),
		.rst(rst),
		.instValid(instValid),
		.regWrite(regWrite),
		.memRead(memRead),
		.writeReg(writeReg),
		.result(result),
		.memData(memData),
		.accept(accept),
		.memReadEn(memReadEn),
		.rfWriteEn(rfWriteEn),
		.rfWriteReg(rfWriteReg),
		.rfWriteData(rfWriteData),
		.busy(busy),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

`default_nettype wire

//--- dv/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int halfPeriodNs = 5
) (
	output logic clk
);

	// free running, first rising edge at halfPeriodNs
	initial begin
		clk = 1'b0;
		forever begin
			#(halfPeriodNs) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- dv/cpuCore_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpuCore_tb;

	//////////////////////////////////////////////////
	// instruction encoding, reference field layout
	localparam logic [3:0] primR      = 4'h0;
	localparam logic [3:0] primMem    = 4'h4;
	localparam logic [3:0] primAddi   = 4'h5;
	localparam logic [3:0] primAddui  = 4'h6;
	localparam logic [3:0] primAddci  = 4'h7;
	localparam logic [3:0] primShift  = 4'h8;
	localparam logic [3:0] primSubi   = 4'h9;
	localparam logic [3:0] primAddcui = 4'ha;
	localparam logic [3:0] primCmpi   = 4'hb;
	localparam logic [3:0] primMovi   = 4'hd;
	localparam logic [3:0] primCmpui  = 4'he;
	localparam logic [3:0] primLui    = 4'hf;

	// pick lists, one 4-bit code per slot
	localparam logic [39:0] rtypeSecs = {4'h5, 4'h6, 4'h7, 4'h4, 4'h9,
		4'h1, 4'h2, 4'h3, 4'hf, 4'hd};
	localparam logic [27:0] immPrims = {primAddi, primAddui, primAddci, primSubi,
		primAddcui, primMovi, primLui};
	localparam logic [23:0] shiftSecs = {4'h4, 4'h5, 4'hc, 4'hd, 4'h0, 4'h1};

	// test lengths
	localparam int numRtype  = 40;
	localparam int numImm    = 32;
	localparam int numShift  = 24;
	localparam int numCmp    = 24;
	localparam int numMemOps = 10;
	localparam int numUndef  = 14;
	localparam int numInst   = `REG_COUNT + numRtype + numImm + numShift + numCmp +
		6 * numMemOps + numUndef + `REG_COUNT;
	localparam int unsigned cycleLimit = 2 * numInst + 50;
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [31:0] cycle;
		logic        wbV;
		logic [3:0]  wbR;
		logic [15:0] wbD;
		logic        bsy;
		logic        c;
		logic        z;
		logic        n;
		logic        l;
	} expEntry_t;

	logic                   clk;
	logic                   rst;
	logic [`INST_WIDTH-1:0] inst;
	logic                   instValid;
	logic                   busy;
	logic                   wbValid;
	logic [3:0]             wbReg;
	logic [`DATA_WIDTH-1:0] wbData;
	logic                   flagC;
	logic                   flagZ;
	logic                   flagN;
	logic                   flagL;

	// reference model state
	logic [15:0] modelRegs [`REG_COUNT];
	logic [15:0] modelMem [`MEM_DEPTH];
	logic        modelC;
	logic        modelZ;
	logic        modelN;
	logic        modelL;

	expEntry_t   expQ [$];
	int unsigned cycleCount = 0;
	logic [7:0]  memAddrs [numMemOps];

	tbClock clockGen0 (
		.clk(clk)
	);

	cpuCore dut0 (
		.clk(clk),
		.rst(rst),
		.inst(inst),
		.instValid(instValid),
		.busy(busy),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.flagC(flagC),
		.flagZ(flagZ),
		.flagN(flagN),
		.flagL(flagL)
	);

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkHex(input string name, input logic [15:0] got, input logic [15:0] want);
		assert (got === want) else begin
			failRun($sformatf("MISMATCH %s got 0x%04h expected 0x%04h", name, got, want));
		end
	endtask

	function automatic logic [17:0] encR(input logic [3:0] prim, input logic [3:0] dst,
		input logic [3:0] sec, input logic [3:0] src);
		return {2'b00, prim, dst, sec, src};
	endfunction

	function automatic logic [17:0] encI(input logic [3:0] prim, input logic [3:0] dst,
		input logic [7:0] imm8);
		return {2'b00, prim, dst, imm8};
	endfunction

	//////////////////////////////////////////////////
	// reference model
	function automatic logic [15:0] addSet(input logic [15:0] x, input logic [15:0] y,
		input logic cin);
		logic [16:0] total;
		total = {1'b0, x} + {1'b0, y} + {16'h0000, cin};
		modelC = total[16];
		return total[15:0];
	endfunction

	// borrow when x is below y
	function automatic logic [15:0] subSet(input logic [15:0] x, input logic [15:0] y);
		modelC = (x < y);
		return x - y;
	endfunction

	function automatic void compareSet(input logic [15:0] x, input logic [15:0] y);
		modelZ = (x == y);
		modelN = ($signed(x) < $signed(y));
		modelL = (x < y);
	endfunction

	// logical shift, then fill the vacated top bits with the sign
	function automatic logic [15:0] shiftRightArith(input logic [15:0] x, input logic [3:0] n);
		logic [15:0] shifted;
		shifted = x >> n;
		if (x[15]) begin
			shifted = shifted | ~(16'hffff >> n);
		end
		return shifted;
	endfunction

	function automatic void predictInst(
		input  logic [`INST_WIDTH-1:0] ins,
		output logic                   wbV,
		output logic [3:0]             wbR,
		output logic [15:0]            wbD,
		output logic                   isLoad
	);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] sx;
		logic [15:0] zx;
		a = modelRegs[ins[11:8]];
		b = modelRegs[ins[3:0]];
		sx = {{8{ins[7]}}, ins[7:0]};
		zx = {8'h00, ins[7:0]};
		wbV = 1'b0;
		wbR = ins[11:8];
		wbD = '0;
		isLoad = 1'b0;
		if (ins[17:16] == 2'b11) begin
			wbV = 1'b1;
			wbD = ins[15:0];
		end else if (ins[17:16] == 2'b00) begin
			case (ins[15:12])
				primR: begin
					wbV = 1'b1;
					case (ins[7:4])
						4'h5, 4'h6: wbD = addSet(a, b, 1'b0);
						4'h7, 4'h4: wbD = addSet(a, b, modelC);
						4'h9: wbD = subSet(a, b);
						4'h1: wbD = a & b;
						4'h2: wbD = a | b;
						4'h3: wbD = a ^ b;
						4'hf: wbD = ~b;
						4'hd: wbD = b;
						4'hb: begin
							compareSet(a, b);
							wbV = 1'b0;
						end
						default: wbV = 1'b0;
					endcase
				end
				primShift: begin
					wbV = 1'b1;
					case (ins[7:4])
						4'h4, 4'h5: wbD = a << b[3:0];
						4'hc: wbD = a >> b[3:0];
						4'hd: wbD = shiftRightArith(a, b[3:0]);
						4'h0: wbD = a << ins[3:0];
						4'h1: wbD = a >> ins[3:0];
						default: wbV = 1'b0;
					endcase
				end
				primMem: begin
					// LOAD address in the low field, STOR address in the high one
					if (ins[7:4] == 4'h0) begin
						wbV = 1'b1;
						isLoad = 1'b1;
						wbD = modelMem[b[7:0]];
					end else if (ins[7:4] == 4'h4) begin
						modelMem[a[7:0]] = b;
					end
				end
				primAddi: begin
					wbV = 1'b1;
					wbD = addSet(a, sx, 1'b0);
				end
				primAddui: begin
					wbV = 1'b1;
					wbD = addSet(a, zx, 1'b0);
				end
				primAddci: begin
					wbV = 1'b1;
					wbD = addSet(a, sx, modelC);
				end
				primAddcui: begin
					wbV = 1'b1;
					wbD = addSet(a, zx, modelC);
				end
				primSubi: begin
					wbV = 1'b1;
					wbD = subSet(a, sx);
				end
				primCmpi: compareSet(a, sx);
				primCmpui: compareSet(a, zx);
				primMovi: begin
					wbV = 1'b1;
					wbD = zx;
				end
				primLui: begin
					wbV = 1'b1;
					wbD = {ins[7:0], 8'h00};
				end
				default: ;
			endcase
		end
		if (wbV) begin
			modelRegs[wbR] = wbD;
		end
	endfunction

	// one expected output set for the coming edge
	function automatic void pushExp(input logic v, input logic [3:0] r, input logic [15:0] d,
		input logic b);
		expEntry_t e;
		e.cycle = cycleCount + 1;
		e.wbV = v;
		e.wbR = r;
		e.wbD = d;
		e.bsy = b;
		e.c = modelC;
		e.z = modelZ;
		e.n = modelN;
		e.l = modelL;
		expQ.push_back(e);
	endfunction

	function automatic logic [17:0] undefInst(input int kind);
		logic [17:0] raw;
		raw = 18'($urandom);
		case (kind)
			0: raw[17:16] = 2'b01;
			1: raw[17:16] = 2'b10;
			2: raw = {2'b00, 4'h1, raw[11:0]};
			3: raw = {2'b00, 4'hc, raw[11:0]};
			4: raw = encR(primR, raw[11:8], 4'he, raw[3:0]);
			5: raw = encR(primShift, raw[11:8], 4'ha, raw[3:0]);
			default: raw = encR(primMem, raw[11:8], 4'h8, raw[3:0]);
		endcase
		return raw;
	endfunction

	//////////////////////////////////////////////////
	// stimulus
	task automatic issueInst(input logic [`INST_WIDTH-1:0] ins);
		logic        v;
		logic [3:0]  r;
		logic [15:0] d;
		logic        isLoad;
		@(posedge clk);
		#1;
		while (busy) begin
			@(posedge clk);
			#1;
		end
		inst = ins;
		instValid = 1'b1;
		predictInst(ins, v, r, d, isLoad);
		if (isLoad) begin
			pushExp(1'b0, r, d, 1'b1);
			@(posedge clk);
			#1;
			inst = '0;
			instValid = 1'b0;
			pushExp(1'b1, r, d, 1'b0);
		end else begin
			pushExp(v, r, d, 1'b0);
		end
	endtask

	task automatic idleBus();
		@(posedge clk);
		#1;
		inst = '0;
		instValid = 1'b0;
	endtask

	initial begin : stimulus
		int unsigned seedSink;
		logic [3:0]  r;
		logic [7:0]  data8;
		logic [15:0] v;
		seedSink = $urandom(68878);
		rst = 1'b1;
		inst = '0;
		instValid = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			modelRegs[i] = '0;
		end
		modelC = 1'b0;
		modelZ = 1'b0;
		modelN = 1'b0;
		modelL = 1'b0;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;

		// quiet outputs after reset
		@(negedge clk);
		checkHex("busy", 16'(busy), 16'h0);
		checkHex("wbValid", 16'(wbValid), 16'h0);
		checkHex("flagC", 16'(flagC), 16'h0);
		checkHex("flagZ", 16'(flagZ), 16'h0);
		checkHex("flagN", 16'(flagN), 16'h0);
		checkHex("flagL", 16'(flagL), 16'h0);

		// long immediate, bits 11:8 of the value name the register
		for (int i = 0; i < `REG_COUNT; i++) begin
			v = {4'($urandom), 4'(i), 8'($urandom)};
			issueInst({2'b11, v});
		end
		for (int i = 0; i < numRtype; i++) begin
			issueInst(encR(primR, 4'($urandom), rtypeSecs[$urandom_range(9) * 4 +: 4],
				4'($urandom)));
		end
		for (int i = 0; i < numImm; i++) begin
			issueInst(encI(immPrims[$urandom_range(6) * 4 +: 4], 4'($urandom),
				8'($urandom)));
		end
		for (int i = 0; i < numShift; i++) begin
			issueInst(encR(primShift, 4'($urandom), shiftSecs[$urandom_range(5) * 4 +: 4],
				4'($urandom)));
		end

		// compares, a register against itself now and then for flagZ
		for (int i = 0; i < numCmp; i++) begin
			r = 4'($urandom);
			case ($urandom_range(2))
				0: issueInst(encR(primR, r, 4'hb, ($urandom_range(3) == 0) ? r : 4'($urandom)));
				1: issueInst(encI(primCmpi, r, 8'($urandom)));
				default: issueInst(encI(primCmpui, r, 8'($urandom)));
			endcase
		end

		// stores through r1 and r2, loads back in reverse order
		for (int i = 0; i < numMemOps; i++) begin
			memAddrs[i] = 8'($urandom);
			data8 = 8'($urandom);
			issueInst({2'b11, 4'($urandom), 4'h1, memAddrs[i]});
			issueInst(encI(primLui, 4'h2, data8));
			issueInst(encI(primAddui, 4'h2, 8'($urandom)));
			issueInst(encR(primMem, 4'h1, 4'h4, 4'h2));
		end
		for (int i = 0; i < numMemOps; i++) begin
			issueInst({2'b11, 4'($urandom), 4'h1, memAddrs[numMemOps - 1 - i]});
			issueInst(encR(primMem, 4'(3 + $urandom_range(12)), 4'h0, 4'h1));
		end

		for (int i = 0; i < numUndef; i++) begin
			issueInst(undefInst(i % 7));
		end
		// every register moved onto itself, reported through writeback
		for (int i = 0; i < `REG_COUNT; i++) begin
			issueInst(encR(primR, 4'(i), 4'hd, 4'(i)));
		end
		idleBus();

		while (expQ.size() != 0) begin
			@(posedge clk);
		end
		$display("Test OK");
		$finish;
	end

	//////////////////////////////////////////////////
	// comparison, half a cycle after each edge
	initial begin : compareOutputs
		expEntry_t e;
		forever begin
			@(negedge clk);
			if (cycleCount >= cycleLimit) begin
				failRun($sformatf("run timed out after %0d cycles", cycleCount));
			end else if (expQ.size() > 0 && expQ[0].cycle == cycleCount) begin
				e = expQ.pop_front();
				checkHex("busy", 16'(busy), 16'(e.bsy));
				checkHex("wbValid", 16'(wbValid), 16'(e.wbV));
				if (e.wbV) begin
					checkHex("wbReg", 16'(wbReg), 16'(e.wbR));
					checkHex("wbData", wbData, e.wbD);
				end
				checkHex("flagC", 16'(flagC), 16'(e.c));
				checkHex("flagZ", 16'(flagZ), 16'(e.z));
				checkHex("flagN", 16'(flagN), 16'(e.n));
				checkHex("flagL", 16'(flagL), 16'(e.l));
			end
		end
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/cpuPkg.sv
source/decoder.sv
source/registerFile.sv
source/executeUnit.sv
source/dataMemory.sv
source/loadSequencer.sv
source/cpuCore.sv
dv/tbClock.sv
dv/cpuCore_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	--top-module cpuCore_tb -f sources.f --Mdir obj_dir

./obj_dir/VcpuCore_tb
